// ==== Bender.yml ====
package:
  name: burst_engine

sources:
  - source/axi_burst_pkg.sv
  - source/wb_pkg.sv
  - source/axi_gen_addr.sv
  - source/burst_cmd_regs.sv
  - source/burst_beat_seq.sv
  - source/burst_engine_top.sv
  - target: test
    files:
      - dv/burst_engine_props.sv
      - dv/burst_engine_tb.sv

// ==== dv/burst_engine_props.sv ====
/*
 * Concurrent checks on the Wishbone handshakes of the burst engine.
 * Bound into every burst_engine_top instance; the testbench reads
 * the failure count at the end of the run.
 */

`timescale 1ns/1ps
`default_nettype none

module burst_engine_props (
    input logic            clk,
    input logic            rst_n,
    input wb_pkg::wb_rsp_t host_rsp,
    input wb_pkg::wb_req_t mem_req,
    input wb_pkg::wb_rsp_t mem_rsp,
    input logic            busy
);
    import wb_pkg::*;

    int assert_fails = 0;

    // Classic master holds the whole request while it waits
    mem_req_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (mem_req.stb && !mem_rsp.ack) |=> $stable(mem_req)
    ) else begin
        $error("memory request changed while stb waited for ack");
        assert_fails++;
    end

    // Registered ack is a single-cycle pulse
    host_ack_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        host_rsp.ack |=> !host_rsp.ack
    ) else begin
        $error("host ack stayed high for more than one cycle");
        assert_fails++;
    end

    // No memory traffic outside a burst
    mem_idle_when_free: assert property (
        @(posedge clk) disable iff (!rst_n)
        !busy |-> (!mem_req.cyc && !mem_req.stb)
    ) else begin
        $error("memory port active while the sequencer is not busy");
        assert_fails++;
    end

endmodule : burst_engine_props

bind burst_engine_top burst_engine_props u_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .host_rsp (host_rsp),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp),
    .busy     (busy)
);

`default_nettype wire

// ==== dv/burst_engine_tb.sv ====
/*
 * Table-driven testbench of the burst engine.
 * Programs each burst over the host port, serves the memory port from a
 * 256-word model with random wait states, and checks against a reference.
 */

`timescale 1ns/1ps
`default_nettype none

module burst_engine_tb;
    import wb_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_TESTS  = 7;
    localparam int MAX_BEATS  = 16;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * MAX_BEATS * 200;

    // Host register byte addresses
    localparam logic [31:0] REG_ADDR    = 32'h00;
    localparam logic [31:0] REG_CTRL    = 32'h04;
    localparam logic [31:0] REG_PATTERN = 32'h08;
    localparam logic [31:0] REG_GO      = 32'h0c;
    localparam logic [31:0] REG_CSUM    = 32'h10;

    typedef struct {
        string       name;
        logic [31:0] addr;
        logic [31:0] ctrl;
        logic [31:0] pattern;
        bit          exp_err;
        int          exp_beats;
        bit          go_twice;
    } test_entry_t;

    logic    clk = 1'b0;
    logic    rst_n;
    wb_req_t host_req;
    wb_rsp_t host_rsp;
    wb_req_t mem_req;
    wb_rsp_t mem_rsp;

    test_entry_t tests [NUM_TESTS];
    logic [31:0] mem [0:255];
    logic [31:0] exp_mem [0:255];
    logic [31:0] acc_log [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_csum;

    integer seed = 32'h0d56_bdd8;
    int     mem_waits = 0;
    bit     mem_pending = 1'b0;
    int     error_count = 0;
    int     tests_failed = 0;
    bit     test_failed;

    burst_engine_top UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Odd multiplier keeps every word distinct
    function automatic logic [31:0] fill_word(input int idx);
        fill_word = (32'(idx) * 32'h0100_0193) ^ 32'h5ac3_0f1e;
    endfunction

    // Beat address stepping by the AXI rules
    function automatic logic [31:0] next_beat_addr(input logic [31:0] a, input int size,
                                                   input int burst, input int len);
        logic [31:0] bytes;
        logic [31:0] blk;
        logic [31:0] base;
        logic [31:0] n;
        bytes = 32'd1 << size;
        blk   = 32'(len + 1) * bytes;
        base  = a - (a % blk);
        n     = (a & ~(bytes - 32'd1)) + bytes;
        case (burst)
            0:       next_beat_addr = a;
            2:       next_beat_addr = (n >= base + blk) ? n - blk : n;
            default: next_beat_addr = a + bytes;
        endcase
    endfunction

    task automatic set_entry(input int idx, input string name, input logic [31:0] addr,
                             input logic [31:0] ctrl, input logic [31:0] pattern,
                             input bit exp_err, input int exp_beats, input bit go_twice);
        tests[idx] = '{name, addr, ctrl, pattern, exp_err, exp_beats, go_twice};
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("** Error %s %s: expected %h, actual %h", name, what, exp, act);
        error_count++;
        test_failed = 1'b1;
    endtask

    // One classic cycle entered 1 ns after a rising edge
    task automatic host_access(input logic we, input logic [31:0] adr,
                               input logic [31:0] wdat, output logic [31:0] rdat);
        host_req.cyc = 1'b1;
        host_req.stb = 1'b1;
        host_req.we  = we;
        host_req.adr = adr;
        host_req.dat = wdat;
        host_req.sel = '1;
        do begin
            @(posedge clk);
            #1;
        end while (!host_rsp.ack);
        rdat     = host_rsp.dat;
        host_req = '0;
    endtask

    task automatic host_write(input logic [31:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        host_access(1'b1, adr, wdat, unused);
    endtask

    task automatic host_read(input logic [31:0] adr, output logic [31:0] rdat);
        host_access(1'b0, adr, 32'h0, rdat);
    endtask

    // Memory side of one acked transfer
    task automatic serve_access();
        int idx;
        idx = int'(mem_req.adr[9:2]);
        acc_log.push_back(mem_req.adr >> 2);
        if (mem_req.we) begin
            for (int k = 0; k < 4; k++) begin
                if (mem_req.sel[k]) begin
                    mem[idx][8*k +: 8] = mem_req.dat[8*k +: 8];
                end
            end
        end
        mem_rsp.dat = mem[idx];
        mem_rsp.ack = 1'b1;
    endtask

    // Memory model with 0 to 3 wait states per transfer
    always begin
        @(posedge clk);
        #1;
        if (mem_rsp.ack) begin
            mem_rsp.ack = 1'b0;
        end else if (mem_req.cyc && mem_req.stb) begin
            if (!mem_pending) begin
                mem_waits   = $unsigned($random(seed)) % 4;
                mem_pending = 1'b1;
            end
            if (mem_waits == 0) begin
                serve_access();
                mem_pending = 1'b0;
            end else begin
                mem_waits--;
            end
        end
    end

    // Expected word addresses, memory image and checksum of one entry
    task automatic build_reference(input int t);
        logic [31:0] a;
        logic [31:0] data;
        int          size;
        int          burst;
        int          len;
        int          bytes;
        int          lane_lo;
        int          lane_hi;
        int          idx;
        exp_addr.delete();
        exp_csum = 32'h0;
        len   = int'(tests[t].ctrl[7:0]);
        size  = int'(tests[t].ctrl[10:8]);
        burst = int'(tests[t].ctrl[13:12]);
        bytes = 1 << size;
        a     = tests[t].addr;
        for (int i = 0; i < tests[t].exp_beats; i++) begin
            idx = int'(a[9:2]);
            exp_addr.push_back(a >> 2);
            if (tests[t].ctrl[16]) begin
                data    = tests[t].pattern + 32'(i);
                // Bytes of the beat starting at its address, clipped to the word
                lane_lo = int'(a[1:0]);
                lane_hi = lane_lo + bytes;
                for (int k = lane_lo; k < lane_hi && k < 4; k++) begin
                    exp_mem[idx][8*k +: 8] = data[8*k +: 8];
                end
            end else begin
                exp_csum = exp_csum + exp_mem[idx];
            end
            a = next_beat_addr(a, size, burst, len);
        end
    endtask

    task automatic run_entry(input int t);
        logic [31:0] status;
        logic [31:0] csum;
        string       name;
        name        = tests[t].name;
        test_failed = 1'b0;
        build_reference(t);
        host_write(REG_ADDR, tests[t].addr);
        host_write(REG_CTRL, tests[t].ctrl);
        host_write(REG_PATTERN, tests[t].pattern);
        acc_log.delete();
        host_write(REG_GO, 32'h1);
        // Second GO lands while the first burst still runs
        if (tests[t].go_twice) begin
            host_write(REG_GO, 32'h1);
        end
        do begin
            host_read(REG_GO, status);
        end while (status[0]);
        host_read(REG_CSUM, csum);

        if (status[1] !== tests[t].exp_err) begin
            report_mismatch(name, "error flag", 32'(tests[t].exp_err), 32'(status[1]));
        end
        // Refused burst leaves count and checksum of the previous one
        if (tests[t].exp_beats != 0 && status[15:8] !== tests[t].exp_beats[7:0]) begin
            report_mismatch(name, "beat count", 32'(tests[t].exp_beats), 32'(status[15:8]));
        end
        if (tests[t].exp_beats != 0 && csum !== exp_csum) begin
            report_mismatch(name, "checksum", exp_csum, csum);
        end
        if (acc_log.size() != exp_addr.size()) begin
            report_mismatch(name, "access count", 32'(exp_addr.size()), 32'(acc_log.size()));
        end
        for (int i = 0; i < acc_log.size() && i < exp_addr.size(); i++) begin
            if (acc_log[i] !== exp_addr[i]) begin
                report_mismatch(name, $sformatf("word address of beat %0d", i),
                                exp_addr[i], acc_log[i]);
            end
        end
        for (int i = 0; i < 256; i++) begin
            if (mem[i] !== exp_mem[i]) begin
                report_mismatch(name, $sformatf("mem[%0d]", i), exp_mem[i], mem[i]);
            end
        end

        // Sticky error clears on a GO write with bit 1 set
        if (tests[t].exp_err) begin
            host_write(REG_GO, 32'h2);
            host_read(REG_GO, status);
            if (status[1] !== 1'b0) begin
                report_mismatch(name, "error flag after clear", 32'h0, 32'(status[1]));
            end
        end
        if (test_failed) begin
            tests_failed++;
        end
        $display("test %-14s %s", name, test_failed ? "failed" : "ok");
    endtask

    initial begin
        host_req = '0;
        mem_rsp  = '0;
        rst_n    = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i]     = fill_word(i);
            exp_mem[i] = fill_word(i);
        end

        // CTRL holds len in 7:0, size in 10:8, burst in 13:12 and write in 16
        set_entry(0, "incr_wr8",     32'h0040, 32'h0001_1207, 32'h1000_0000, 0, 8,  0);
        set_entry(1, "wrap_rd4",     32'h0088, 32'h0000_2203, 32'h0000_0000, 0, 4,  0);
        set_entry(2, "fixed_wr5",    32'h0100, 32'h0001_0204, 32'h2000_0000, 0, 5,  0);
        set_entry(3, "incr_byte_wr", 32'h0141, 32'h0001_1005, 32'h4433_2210, 0, 6,  0);
        set_entry(4, "wrap_len3",    32'h0180, 32'h0001_2202, 32'h3000_0000, 1, 0,  0);
        set_entry(5, "go_while_busy",32'h0200, 32'h0001_120f, 32'h5000_0000, 1, 16, 1);
        set_entry(6, "incr_rd_back", 32'h0040, 32'h0000_1207, 32'h0000_0000, 0, 8,  0);

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_entry(t);
        end

        // Bound assertion failures count against the run
        error_count += UUT.u_props.assert_fails;
        $display("Tests run: %0d, failed: %0d, errors: %0d",
                 NUM_TESTS, tests_failed, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: the engine or the host port stopped responding");
        $display("*** FAILED ***");
        $finish;
    end

endmodule : burst_engine_tb

`default_nettype wire

// ==== filelist.f ====
source/axi_burst_pkg.sv
source/wb_pkg.sv
source/axi_gen_addr.sv
source/burst_cmd_regs.sv
source/burst_beat_seq.sv
source/burst_engine_top.sv
dv/burst_engine_props.sv
dv/burst_engine_tb.sv

// ==== source/axi_burst_pkg.sv ====
/*
 * AXI-style burst description types shared by the burst engine.
 * Holds the default widths, the burst type encoding and the packed
 * command that the register file hands to the beat sequencer.
 */

`default_nettype none

package axi_burst_pkg;

    // Default widths, picked up by the top level parameters
    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;
    parameter int LEN_W  = 8;

    // Byte address
    typedef logic [ADDR_W-1:0] addr_t;

    // Beat count minus one
    typedef logic [LEN_W-1:0] len_t;

    // Log2 of bytes per beat
    typedef logic [2:0] size_t;

    // Burst type, AXI encoding
    // Code 3 is reserved and behaves as INCR
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_e;

    // One complete burst request
    typedef struct packed {
        addr_t  addr;
        len_t   len;
        size_t  size;
        burst_e burst;
        logic   write;
    } burst_cmd_t;

endpackage : axi_burst_pkg

`default_nettype wire

// ==== source/axi_gen_addr.sv ====
/*
 * Next-beat address generator for FIXED, INCR and WRAP bursts.
 * Purely combinational. Feed it the current beat address and read back
 * the next beat address and the same address aligned to the output word.
 */

`timescale 1ns/1ps
`default_nettype none

module axi_gen_addr #(
    parameter int AW  = 32,
    parameter int DW  = 32,
    parameter int ODW = 32,
    parameter int LEN = 8
) (
    input  logic [AW-1:0]         curr_addr,
    input  axi_burst_pkg::size_t  size,
    input  axi_burst_pkg::burst_e burst,
    input  logic [LEN-1:0]        len,
    output logic [AW-1:0]         next_addr,
    output logic [AW-1:0]         next_addr_align
);
    import axi_burst_pkg::*;

    localparam int ODWBYTES = ODW / 8;

    logic [AW-1:0] incr_raw;
    logic [AW-1:0] incr;
    logic [AW-1:0] wrap_mask;
    logic [AW-1:0] incr_align;
    logic [AW-1:0] wrap_addr;
    logic [AW-1:0] word_mask;

    always_comb begin
        // Bytes per beat
        incr_raw = AW'(1) << size;
        incr     = incr_raw;
        // Narrow output port caps the step
        if (DW != ODW && incr_raw > AW'(ODWBYTES)) begin
            incr = AW'(ODWBYTES);
        end

        // Block of beats * bytes, power of two for legal wraps
        wrap_mask = ((AW'(len) + AW'(1)) << size) - AW'(1);

        // Step then snap to the beat size
        incr_align = (curr_addr + incr) & ~(incr - AW'(1));

        // Upper bits from current block, lower bits from stepped addr
        wrap_addr = (curr_addr & ~wrap_mask) | (incr_align & wrap_mask);
    end

    always_comb begin
        case (burst)
            BURST_FIXED: next_addr = curr_addr;
            BURST_INCR:  next_addr = curr_addr + incr;
            BURST_WRAP:  next_addr = wrap_addr;
            // Reserved code
            default:     next_addr = curr_addr + incr;
        endcase
    end

    // Output word alignment
    assign word_mask       = AW'(ODWBYTES - 1);
    assign next_addr_align = next_addr & ~word_mask;

endmodule : axi_gen_addr

`default_nettype wire

// ==== source/burst_beat_seq.sv ====
/*
 * Beat sequencer of the burst engine.
 * Latches a command on start and runs one Wishbone classic transfer per
 * beat on the memory port, stepping the address with axi_gen_addr.
 */

`timescale 1ns/1ps
`default_nettype none

module burst_beat_seq #(
    parameter int AW  = axi_burst_pkg::ADDR_W,
    parameter int DW  = axi_burst_pkg::DATA_W,
    parameter int ODW = axi_burst_pkg::DATA_W,
    parameter int LEN = axi_burst_pkg::LEN_W
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  axi_burst_pkg::burst_cmd_t cmd,
    input  wb_pkg::data_t             pattern,
    input  logic                      start,
    output wb_pkg::wb_req_t           mem_req,
    input  wb_pkg::wb_rsp_t           mem_rsp,
    output logic                      busy,
    output logic                      beat_done,
    output wb_pkg::data_t             rd_data
);
    import axi_burst_pkg::*;
    import wb_pkg::*;

    localparam int ODWBYTES = ODW / 8;
    localparam int SELW     = DW / 8;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_REQ,
        SEQ_GAP
    } seq_state_e;

    seq_state_e     state_q;
    logic [LEN-1:0] beat_idx_q;

    // Latched burst
    logic [AW-1:0]  beat_addr_q;
    logic [AW-1:0]  adr_q;
    logic [LEN-1:0] len_q;
    size_t          size_q;
    burst_e         burst_q;
    logic           we_q;
    data_t          pattern_q;

    logic [AW-1:0]  next_addr;
    logic [AW-1:0]  next_addr_align;
    logic [AW-1:0]  align_mask;
    logic [AW-1:0]  start_align;
    logic [AW-1:0]  beat_bytes;
    logic [AW-1:0]  lane_off;
    logic [AW-1:0]  lane_end;
    sel_t           sel_c;
    logic           ack_beat;
    logic           last_beat;

    axi_gen_addr #(
        .AW  (AW),
        .DW  (DW),
        .ODW (ODW),
        .LEN (LEN)
    ) u_gen_addr (
        .curr_addr       (beat_addr_q),
        .size            (size_q),
        .burst           (burst_q),
        .len             (len_q),
        .next_addr       (next_addr),
        .next_addr_align (next_addr_align)
    );

    // First beat aligned here
    assign align_mask  = AW'(ODWBYTES - 1);
    assign start_align = AW'(cmd.addr) & ~align_mask;

    assign ack_beat  = (state_q == SEQ_REQ) && mem_rsp.ack;
    assign last_beat = (beat_idx_q == len_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= SEQ_IDLE;
            beat_idx_q <= '0;
        end else begin
            case (state_q)
                SEQ_IDLE: begin
                    if (start) begin
                        state_q    <= SEQ_REQ;
                        beat_idx_q <= '0;
                    end
                end
                SEQ_REQ: begin
                    // Hold the request until the memory acks
                    if (mem_rsp.ack) begin
                        if (last_beat) begin
                            state_q <= SEQ_IDLE;
                        end else begin
                            state_q    <= SEQ_GAP;
                            beat_idx_q <= beat_idx_q + 1'b1;
                        end
                    end
                end
                // One idle cycle between beats
                SEQ_GAP: state_q <= SEQ_REQ;
                default: state_q <= SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == SEQ_IDLE && start) begin
            beat_addr_q <= AW'(cmd.addr);
            adr_q       <= start_align;
            len_q       <= LEN'(cmd.len);
            size_q      <= cmd.size;
            burst_q     <= cmd.burst;
            we_q        <= cmd.write;
            pattern_q   <= pattern;
        end else if (ack_beat) begin
            beat_addr_q <= next_addr;
            adr_q       <= next_addr_align;
        end
    end

    // Lanes from the beat address to the end of its size container
    always_comb begin
        beat_bytes = AW'(1) << size_q;
        lane_off   = beat_addr_q & align_mask;
        lane_end   = (lane_off & ~(beat_bytes - AW'(1))) + beat_bytes;
        for (int i = 0; i < SELW; i++) begin
            sel_c[i] = (i < ODWBYTES) && (AW'(i) >= lane_off) && (AW'(i) < lane_end);
        end
    end

    always_comb begin
        mem_req.cyc = (state_q == SEQ_REQ);
        mem_req.stb = (state_q == SEQ_REQ);
        mem_req.we  = we_q;
        mem_req.adr = addr_t'(adr_q);
        // Pattern plus beat index
        mem_req.dat = pattern_q + data_t'(beat_idx_q);
        mem_req.sel = sel_c;
    end

    assign busy      = (state_q != SEQ_IDLE);
    assign beat_done = ack_beat;
    // Zero on write beats so the checksum only sees reads
    assign rd_data   = (ack_beat && !we_q) ? mem_rsp.dat : '0;

endmodule : burst_beat_seq

`default_nettype wire

// ==== source/burst_cmd_regs.sv ====
/*
 * Host-facing Wishbone classic register file of the burst engine.
 * Holds ADDR, CTRL and PATTERN, checks GO requests, and keeps status,
 * the completed beat count and the read checksum.
 */

`timescale 1ns/1ps
`default_nettype none

module burst_cmd_regs #(
    parameter int AW  = axi_burst_pkg::ADDR_W,
    parameter int DW  = axi_burst_pkg::DATA_W,
    parameter int LEN = axi_burst_pkg::LEN_W
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  wb_pkg::wb_req_t           host_req,
    output wb_pkg::wb_rsp_t           host_rsp,
    output axi_burst_pkg::burst_cmd_t cmd,
    output wb_pkg::data_t             pattern,
    output logic                      start,
    input  logic                      busy,
    input  logic                      beat_done,
    input  wb_pkg::data_t             rd_data
);
    import axi_burst_pkg::*;
    import wb_pkg::*;

    // Word offsets
    localparam logic [2:0] OFF_ADDR    = 3'd0;
    localparam logic [2:0] OFF_CTRL    = 3'd1;
    localparam logic [2:0] OFF_PATTERN = 3'd2;
    localparam logic [2:0] OFF_GO      = 3'd3;
    localparam logic [2:0] OFF_CSUM    = 3'd4;

    logic [AW-1:0]  addr_q;
    logic [LEN-1:0] len_q;
    size_t          size_q;
    burst_e         burst_q;
    logic           write_q;
    data_t          pattern_q;
    logic           err_q;
    logic [LEN:0]   beat_cnt_q;
    logic [DW-1:0]  csum_q;
    logic           ack_q;
    data_t          rdat_q;
    logic           go_pend_q;
    logic           start_q;

    logic           req_hit;
    logic [2:0]     woff;
    logic           engaged;
    logic           wrap_ok;
    logic           go_wr;
    logic           clr_wr;
    data_t          rd_mux;

    // New access, not the cycle already acked
    assign req_hit = host_req.cyc && host_req.stb && !ack_q;
    assign woff    = host_req.adr[4:2];

    // Busy from GO until the sequencer drops busy
    assign engaged = busy || go_pend_q || start_q;

    // WRAP needs 2, 4, 8 or 16 beats
    assign wrap_ok = (burst_q != BURST_WRAP) ||
                     (len_q == LEN'(1)) || (len_q == LEN'(3)) ||
                     (len_q == LEN'(7)) || (len_q == LEN'(15));

    // Bit 1 set means clear error, otherwise a start request
    assign go_wr  = req_hit && host_req.we && (woff == OFF_GO) && !host_req.dat[1];
    assign clr_wr = req_hit && host_req.we && (woff == OFF_GO) && host_req.dat[1];

    always_comb begin
        rd_mux = '0;
        case (woff)
            OFF_ADDR:    rd_mux = data_t'(addr_q);
            OFF_CTRL: begin
                rd_mux[7:0]   = 8'(len_q);
                rd_mux[10:8]  = size_q;
                rd_mux[13:12] = burst_q;
                rd_mux[16]    = write_q;
            end
            OFF_PATTERN: rd_mux = pattern_q;
            OFF_GO: begin
                rd_mux[0]    = engaged;
                rd_mux[1]    = err_q;
                rd_mux[15:8] = 8'(beat_cnt_q);
            end
            OFF_CSUM:    rd_mux = data_t'(csum_q);
            default:     rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q      <= 1'b0;
            go_pend_q  <= 1'b0;
            start_q    <= 1'b0;
            err_q      <= 1'b0;
            beat_cnt_q <= '0;
            csum_q     <= '0;
            addr_q     <= '0;
            len_q      <= '0;
            size_q     <= 3'd2;
            burst_q    <= BURST_INCR;
            write_q    <= 1'b0;
            pattern_q  <= '0;
        end else begin
            ack_q <= req_hit;

            // GO accepted one cycle, start pulse the next
            go_pend_q <= go_wr && !engaged && wrap_ok;
            start_q   <= go_pend_q;

            // Sticky until cleared by the host
            if (clr_wr) begin
                err_q <= 1'b0;
            end else if (go_wr && (engaged || !wrap_ok)) begin
                err_q <= 1'b1;
            end

            // Per-burst counters
            if (go_pend_q) begin
                beat_cnt_q <= '0;
                csum_q     <= '0;
            end else if (beat_done) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
                // Zero on write beats
                csum_q     <= csum_q + DW'(rd_data);
            end

            if (req_hit && host_req.we) begin
                case (woff)
                    OFF_ADDR:    addr_q <= AW'(host_req.dat);
                    OFF_CTRL: begin
                        len_q   <= LEN'(host_req.dat[7:0]);
                        size_q  <= host_req.dat[10:8];
                        burst_q <= burst_e'(host_req.dat[13:12]);
                        write_q <= host_req.dat[16];
                    end
                    OFF_PATTERN: pattern_q <= host_req.dat;
                    default: ;
                endcase
            end
        end
    end

    // Read data captured with the request
    always_ff @(posedge clk) begin
        if (req_hit && !host_req.we) begin
            rdat_q <= rd_mux;
        end
    end

    assign host_rsp.ack = ack_q;
    assign host_rsp.dat = rdat_q;

    assign cmd = '{addr: addr_t'(addr_q), len: len_t'(len_q), size: size_q,
                   burst: burst_q, write: write_q};
    assign pattern = pattern_q;
    assign start   = start_q;

endmodule : burst_cmd_regs

`default_nettype wire

// ==== source/burst_engine_top.sv ====
/*
 * Burst memory engine top level.
 * Host programs bursts through the Wishbone slave port, and the engine
 * replays them as single Wishbone classic transfers on the memory port.
 */

`timescale 1ns/1ps
`default_nettype none

module burst_engine_top #(
    parameter int AW  = axi_burst_pkg::ADDR_W,
    parameter int DW  = axi_burst_pkg::DATA_W,
    parameter int ODW = axi_burst_pkg::DATA_W,
    parameter int LEN = axi_burst_pkg::LEN_W
) (
    input  logic            clk,
    input  logic            rst_n,
    input  wb_pkg::wb_req_t host_req,
    output wb_pkg::wb_rsp_t host_rsp,
    output wb_pkg::wb_req_t mem_req,
    input  wb_pkg::wb_rsp_t mem_rsp
);
    import axi_burst_pkg::*;
    import wb_pkg::*;

    // Register file to sequencer
    burst_cmd_t cmd;
    data_t      pattern;
    logic       start;

    // Sequencer back to register file
    logic       busy;
    logic       beat_done;
    data_t      rd_data;

    burst_cmd_regs #(
        .AW  (AW),
        .DW  (DW),
        .LEN (LEN)
    ) u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .host_req  (host_req),
        .host_rsp  (host_rsp),
        .cmd       (cmd),
        .pattern   (pattern),
        .start     (start),
        .busy      (busy),
        .beat_done (beat_done),
        .rd_data   (rd_data)
    );

    burst_beat_seq #(
        .AW  (AW),
        .DW  (DW),
        .ODW (ODW),
        .LEN (LEN)
    ) u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .pattern   (pattern),
        .start     (start),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .busy      (busy),
        .beat_done (beat_done),
        .rd_data   (rd_data)
    );

endmodule : burst_engine_top

`default_nettype wire

// ==== source/wb_pkg.sv ====
/*
 * Wishbone classic request and response structs.
 * Used unchanged on the host register port and the memory master port.
 */

`default_nettype none

package wb_pkg;

    // Data word and its byte lanes
    typedef logic [axi_burst_pkg::DATA_W-1:0]   data_t;
    typedef logic [axi_burst_pkg::DATA_W/8-1:0] sel_t;

    // Master to slave
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        axi_burst_pkg::addr_t adr;
        data_t                dat;
        sel_t                 sel;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic  ack;
        data_t dat;
    } wb_rsp_t;

endpackage : wb_pkg

`default_nettype wire
